// File: par_queue_top.f
+incdir+logic
logic/pq_types_pkg.sv
logic/pq_ctrl_pkg.sv
logic/parity_check.sv
logic/par_queue_store.sv
logic/par_err_log.sv
logic/par_queue_top.sv
tests/tb_clk_gen.sv
tests/par_queue_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the parity queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module par_queue_tb \
  -f par_queue_top.f \
  -o sim_par_queue

# The simulator exit status is not trusted, the log decides
./obj_dir/sim_par_queue | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if ! grep -q "\*\* PASS \*\*" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation finished cleanly"

// File: tests/par_queue_tb.sv
// Parity queue testbench

`timescale 1ns/1ps
`include "pq_defines.svh"

module par_queue_tb
  import pq_types_pkg::*;
  import pq_ctrl_pkg::*;
();

  // ------------------------------------------------------------
  // Run length and stimulus constants
  // ------------------------------------------------------------

  // Four full batches plus the two items of the clear test
  localparam int TOTAL_ITEMS = 4 * `PQ_DEPTH + 2;
  // Each item needs a few cycles, the margin covers resets and idle gaps
  localparam int CYCLE_LIMIT = TOTAL_ITEMS * 4 + 300;
  // Items 2, 3 and 6 of the injection batch carry a planted parity fault
  localparam logic [`PQ_DEPTH-1:0] INJ_MASK = 8'b0100_1100;

  logic           clk;
  logic           rst_n;
  logic           reset_req;
  logic           par_odd;
  logic           in_valid;
  pq_item_t       in_item;
  logic           inj_par;
  logic           in_credit;
  logic           out_credit;
  logic           out_valid;
  pq_item_t       out_item;
  logic           out_par_err;
  logic           err_clr;
  pq_err_status_t err_status;

  // Model state
  pq_item_t    exp_items [$];
  logic        exp_errs [$];
  pq_item_t    exp_item;
  logic        exp_err;
  int          prod_cred = `PQ_DEPTH;
  int          out_count = 0;
  int          cycle_cnt = 0;
  logic [31:0] lcg_state = 32'he634;
  logic        failed = 1'b0;

  tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(10)) u_clk_gen (
    .reset_req (reset_req),
    .clk       (clk),
    .rst_n     (rst_n)
  );

  par_queue_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .par_odd     (par_odd),
    .in_valid    (in_valid),
    .in_item     (in_item),
    .inj_par     (inj_par),
    .in_credit   (in_credit),
    .out_credit  (out_credit),
    .out_valid   (out_valid),
    .out_item    (out_item),
    .out_par_err (out_par_err),
    .err_clr     (err_clr),
    .err_status  (err_status)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic pq_item_t random_item();
    pq_item_t    it;
    logic [31:0] r;
    it.data = next_rand();
    r = next_rand();
    // Upper LCG bits are better mixed than the lowest ones
    it.tag = r[27:24];
    return it;
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      failed = 1'b1;
      $display("ERR %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    failed = 1'b1;
    $display("At %0d ns: %s", $time, why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  // Writes one item once a producer credit is available
  task automatic write_item(input pq_item_t item, input logic inj);
    @(posedge clk);
    while (prod_cred == 0) begin
      in_valid <= 1'b0;
      @(posedge clk);
    end
    in_valid <= 1'b1;
    in_item  <= item;
    inj_par  <= inj;
    prod_cred--;
    exp_items.push_back(item);
    // An entry flags a parity error exactly when it was written with injection
    exp_errs.push_back(inj);
  endtask

  task automatic end_writes();
    @(posedge clk);
    in_valid <= 1'b0;
    inj_par  <= 1'b0;
  endtask

  task automatic grant_credits(input int n);
    repeat (n) begin
      @(posedge clk);
      out_credit <= 1'b1;
      @(posedge clk);
      out_credit <= 1'b0;
    end
  endtask

  // Returns at a falling edge once the logger has seen the last item
  task automatic wait_drain();
    while (exp_items.size() != 0) @(posedge clk);
    @(negedge clk);
    check_eq(64'(prod_cred), 64'(`PQ_DEPTH), "producer credits after drain");
  endtask

  task automatic check_status(input pq_err_state_e st, input int cnt, input string what);
    check_eq(64'(err_status.state), 64'(st), {what, " state"});
    check_eq(64'(err_status.count), 64'(cnt), {what, " count"});
  endtask

  task automatic apply_reset(input logic odd);
    @(posedge clk);
    reset_req <= 1'b1;
    while (rst_n) @(posedge clk);
    reset_req <= 1'b0;
    // Parity mode only changes while the DUT is held in reset
    par_odd <= odd;
    while (!rst_n) @(posedge clk);
  endtask

  // ------------------------------------------------------------
  // Output monitor and watchdog
  // ------------------------------------------------------------

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (in_credit !== out_valid) abort_run("in_credit did not pulse together with out_valid");
      if (in_credit === 1'b1) prod_cred++;
      if (prod_cred > `PQ_DEPTH) abort_run("producer credits exceeded the store depth");
      if (out_valid === 1'b1) begin
        if (exp_items.size() == 0) begin
          abort_run("DUT sent an item that was never written");
        end else begin
          exp_item = exp_items.pop_front();
          exp_err  = exp_errs.pop_front();
          check_eq(64'(out_item), 64'(exp_item), "out_item value or order");
          check_eq(64'(out_par_err), 64'(exp_err), "out_par_err");
          out_count++;
        end
      end else begin
        check_eq(64'(out_par_err), 64'd0, "out_par_err while idle");
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) abort_run("timeout, the tests did not finish in time");
  end

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  task automatic run_batch(input logic [`PQ_DEPTH-1:0] inj_mask, output int n_inj,
                           output logic [`PQ_TAG_W-1:0] first_tag);
    pq_item_t item;
    n_inj = 0;
    first_tag = '0;
    grant_credits(`PQ_DEPTH);
    for (int i = 0; i < `PQ_DEPTH; i++) begin
      item = random_item();
      if (inj_mask[i]) begin
        if (n_inj == 0) first_tag = item.tag;
        n_inj++;
      end
      write_item(item, inj_mask[i]);
    end
    end_writes();
    wait_drain();
  endtask

  task automatic test_back_pressure();
    int       writes;
    int       base;
    pq_item_t item;
    writes = 0;
    // No consumer credits, so the store fills until the producer stalls
    while (prod_cred > 0) begin
      item = random_item();
      write_item(item, 1'b0);
      writes++;
    end
    end_writes();
    check_eq(64'(writes), 64'(`PQ_DEPTH), "writes before producer stall");
    base = out_count;
    repeat (6) @(posedge clk);
    check_eq(64'(out_count), 64'(base), "items sent without consumer credit");
    for (int i = 0; i < `PQ_DEPTH; i++) begin
      grant_credits(1);
      repeat (4) @(posedge clk);
      check_eq(64'(out_count), 64'(base + i + 1), "items released per grant");
    end
    wait_drain();
  endtask

  initial begin
    int                   n_inj;
    logic [`PQ_TAG_W-1:0] first_tag;
    pq_item_t             item;
    reset_req  = 1'b0;
    par_odd    = 1'b0;
    in_valid   = 1'b0;
    in_item    = '0;
    inj_par    = 1'b0;
    out_credit = 1'b0;
    err_clr    = 1'b0;
    while (rst_n !== 1'b1) @(posedge clk);

    // In-order transfer with even parity
    run_batch('0, n_inj, first_tag);
    check_status(ERR_CLEAN, 0, "even parity status");

    test_back_pressure();

    // Odd parity after a fresh reset
    apply_reset(1'b1);
    run_batch('0, n_inj, first_tag);
    check_status(ERR_CLEAN, 0, "odd parity status");

    // Injection and logging
    run_batch(INJ_MASK, n_inj, first_tag);
    check_status(ERR_SEEN, n_inj, "injection status");
    check_eq(64'(err_status.first_tag), 64'(first_tag), "first error tag");

    // Clear, then a new error records its own tag
    @(posedge clk);
    err_clr <= 1'b1;
    @(posedge clk);
    err_clr <= 1'b0;
    @(negedge clk);
    check_status(ERR_CLEAN, 0, "status after clear");
    grant_credits(2);
    write_item(random_item(), 1'b0);
    item = random_item();
    write_item(item, 1'b1);
    end_writes();
    wait_drain();
    check_status(ERR_SEEN, 1, "status after clear and new error");
    check_eq(64'(err_status.first_tag), 64'(item.tag), "tag after clear");

    if (!failed) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: tests/tb_clk_gen.sv
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 10
) (
  input  logic reset_req,
  output logic clk,
  output logic rst_n
);

  // Cycles of reset still to run, reset is released when it reaches zero
  logic [7:0] rst_cnt;

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;

  // Power-on reset, and a fresh reset whenever the testbench asks for one
  initial rst_cnt = 8'(RST_CYCLES);
  always @(posedge clk) begin
    if (reset_req) begin
      rst_cnt <= 8'(RST_CYCLES);
    end else if (rst_cnt != '0) begin
      rst_cnt <= rst_cnt - 8'd1;
    end
  end

  assign rst_n = (rst_cnt == '0);

endmodule

// File: logic/par_queue_top.sv
// Parity queue top level

`timescale 1ns/1ps

module par_queue_top
  import pq_types_pkg::*;
  import pq_ctrl_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           par_odd,
  input  logic           in_valid,
  input  pq_item_t       in_item,
  input  logic           inj_par,
  output logic           in_credit,
  input  logic           out_credit,
  output logic           out_valid,
  output pq_item_t       out_item,
  output logic           out_par_err,
  input  logic           err_clr,
  output pq_err_status_t err_status
);

  pq_entry_t out_entry;

  // ------------------------------------------------------------
  // Store with parity generation and credit counters
  // ------------------------------------------------------------

  par_queue_store u_store (
    .clk        (clk),
    .rst_n      (rst_n),
    .par_odd    (par_odd),
    .in_valid   (in_valid),
    .in_item    (in_item),
    .inj_par    (inj_par),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_entry  (out_entry),
    .in_credit  (in_credit)
  );

  // The parity bit stays inside, the consumer only sees the item
  assign out_item = out_entry.item;

  // ------------------------------------------------------------
  // Check on the registered output
  // ------------------------------------------------------------

  // Flag is combinational so it lines up with out_valid
  parity_check #(
    .WIDTH ($bits(pq_item_t))
  ) u_check (
    .p   (out_entry.par),
    .d   (out_entry.item),
    .e   (out_valid),
    .odd (par_odd),
    .err (out_par_err)
  );

  // Logger sees the flag and the tag of the entry that raised it
  par_err_log u_err_log (
    .clk        (clk),
    .rst_n      (rst_n),
    .par_err    (out_par_err),
    .err_tag    (out_entry.item.tag),
    .err_clr    (err_clr),
    .err_status (err_status)
  );

endmodule

// File: logic/par_err_log.sv
// Parity error logger

`timescale 1ns/1ps
`include "pq_defines.svh"

module par_err_log
  import pq_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 par_err,
  input  logic [`PQ_TAG_W-1:0] err_tag,
  input  logic                 err_clr,
  output pq_err_status_t       err_status
);

  // Status value after reset or a software clear
  localparam pq_err_status_t STATUS_CLR = '{
    state:     ERR_CLEAN,
    count:     '0,
    first_tag: '0
  };

  pq_err_status_t status_nxt;

  // ------------------------------------------------------------
  // Next status
  // ------------------------------------------------------------

  always_comb begin
    status_nxt = err_status;
    if (err_clr) begin
      // A clear wins over an error in the same cycle, that error is dropped
      status_nxt = STATUS_CLR;
    end else if (par_err) begin
      // Counter sticks at all ones rather than wrapping to zero
      if (err_status.count != '1) begin
        status_nxt.count = err_status.count + 1'b1;
      end
      // Only the first error after a clear records its tag
      if (err_status.state == ERR_CLEAN) begin
        status_nxt.first_tag = err_tag;
      end
      status_nxt.state = ERR_SEEN;
    end
  end

  // ------------------------------------------------------------
  // Status register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_status <= STATUS_CLR;
    end else begin
      err_status <= status_nxt;
    end
  end

  // The FSM and the counter move together, so SEEN implies at least one error
  a_seen_counted : assert property (
    @(posedge clk) disable iff (!rst_n)
    (err_status.state == ERR_SEEN) |-> (err_status.count != '0)
  ) else $error("par_err_log: ERR_SEEN with zero error count");

endmodule

// File: logic/par_queue_store.sv
// Parity queue entry store

`timescale 1ns/1ps
`include "pq_defines.svh"

module par_queue_store
  import pq_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      par_odd,
  input  logic      in_valid,
  input  pq_item_t  in_item,
  input  logic      inj_par,
  input  logic      out_credit,
  output logic      out_valid,
  output pq_entry_t out_entry,
  output logic      in_credit
);

  // Pointer width indexes the memory, count width must also hold PQ_DEPTH itself
  localparam int PTR_W = $clog2(`PQ_DEPTH);
  localparam int CNT_W = $clog2(`PQ_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX  = PTR_W'(`PQ_DEPTH - 1);
  localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(`PQ_DEPTH);

  pq_entry_t        mem [`PQ_DEPTH];
  pq_entry_t        wr_entry;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] occ;
  logic [CNT_W-1:0] cons_cred;
  logic             wr_en;
  logic             send;

  // ------------------------------------------------------------
  // Write side
  // ------------------------------------------------------------

  // The producer only drives in_valid while it holds a credit
  // So every valid cycle is a write
  assign wr_en = in_valid;

  // Parity is even over the item by default
  // par_odd flips it for odd mode and inj_par flips it once more to plant a fault
  always_comb begin
    wr_entry.item = in_item;
    wr_entry.par  = ^in_item ^ par_odd ^ inj_par;
  end

  // Occupancy tells which slots hold live entries
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  // ------------------------------------------------------------
  // Read side and credit bookkeeping
  // ------------------------------------------------------------

  // An entry leaves whenever one is stored and the consumer has granted room
  // Entries written this cycle are not visible yet, so there is no bypass
  assign send = (occ != '0) && (cons_cred != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occ       <= '0;
      cons_cred <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      // Both counters may move up and down in the same cycle
      occ       <= occ + CNT_W'(wr_en) - CNT_W'(send);
      cons_cred <= cons_cred + CNT_W'(out_credit) - CNT_W'(send);
    end
  end

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------

  // Valid marks the single cycle in which an entry is presented
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= send;
    end
  end

  // Payload register only loads on a send and holds otherwise
  always_ff @(posedge clk) begin
    if (send) begin
      out_entry <= mem[rd_ptr];
    end
  end

  // The slot freed by a send goes back to the producer in the same cycle
  // that the entry shows on the output
  assign in_credit = out_valid;

  // ------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------

  // A producer that writes into a full store has spent a credit it never had
  a_no_write_full : assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> (occ != DEPTH_CNT)
  ) else $error("par_queue_store: write while full, producer credit violated");

  // Occupancy must stay within the memory across all cycles
  a_occ_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    occ <= DEPTH_CNT
  ) else $error("par_queue_store: occupancy overflow");

  // The consumer cannot grant more room than the store has entries
  a_cred_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    cons_cred <= DEPTH_CNT
  ) else $error("par_queue_store: consumer credits exceed depth");

endmodule

// File: logic/parity_check.sv
// Parity checker

`timescale 1ns/1ps

module parity_check #(
  parameter int WIDTH = 1
) (
  input  logic             p,
  input  logic [WIDTH-1:0] d,
  input  logic             e,
  input  logic             odd,
  output logic             err
);

  // ------------------------------------------------------------
  // Mismatch detection
  // ------------------------------------------------------------

  // With even parity the XOR of data and parity bit must be zero
  // Odd mode flips the expected value, so odd joins the reduction
  // The enable masks the flag on cycles that carry no data
  assign err = e & ^{odd, p, d};

  // Unknown bits would make the flag meaningless while enabled
  always_comb begin
    if (e) begin
      assert (!$isunknown({odd, p, d}))
        else $error("parity_check: unknown input while enabled");
    end
  end

endmodule

// File: logic/pq_ctrl_pkg.sv
// Error logger control types

`include "pq_defines.svh"

package pq_ctrl_pkg;

  // ------------------------------------------------------------
  // Logger state
  // ------------------------------------------------------------

  // CLEAN means no error since reset or the last clear
  typedef enum logic {
    ERR_CLEAN = 1'b0,
    ERR_SEEN  = 1'b1
  } pq_err_state_e;

  // ------------------------------------------------------------
  // Status word visible at the top level
  // ------------------------------------------------------------

  // The tag field only carries meaning while the state is ERR_SEEN
  typedef struct packed {
    pq_err_state_e             state;
    logic [`PQ_ERR_CNT_W-1:0]  count;
    logic [`PQ_TAG_W-1:0]      first_tag;
  } pq_err_status_t;

endpackage

// File: logic/pq_types_pkg.sv
// Queue datapath types

`include "pq_defines.svh"

package pq_types_pkg;

  // ------------------------------------------------------------
  // Item as seen by producer and consumer
  // ------------------------------------------------------------

  // Tag sits in the low bits so it lines up with the parity bit below it
  typedef struct packed {
    logic [`PQ_DATA_W-1:0] data;
    logic [`PQ_TAG_W-1:0]  tag;
  } pq_item_t;

  // ------------------------------------------------------------
  // Entry as held in the store
  // ------------------------------------------------------------

  // One item plus the parity bit generated at write time
  typedef struct packed {
    pq_item_t item;
    logic     par;
  } pq_entry_t;

endpackage

// File: logic/pq_defines.svh
// Parity queue sizing macros

`ifndef PQ_DEFINES_SVH
`define PQ_DEFINES_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------

// Payload word carried by every item
`define PQ_DATA_W 32

// Tag that travels with the payload and is logged on a parity error
`define PQ_TAG_W 4

// ------------------------------------------------------------
// Store and logger sizing
// ------------------------------------------------------------

// Entries in the store, which is also the producer's starting credit count
`define PQ_DEPTH 8

// Parity error counter width, the counter saturates at all ones
`define PQ_ERR_CNT_W 8

`endif
